//--- src.f
src/exec_pkg.sv
src/exec_alu.sv
src/branch_unit.sv
src/exu.sv
src/csr_file.sv
src/btb.sv
src/exec_top.sv
bench/exec_tb.sv

//--- Makefile
# Verilator build and run for the execute stage testbench
# run from the project root, the testbench opens bench/exec_input.txt

VERILATOR ?= verilator
TOP       ?= exec_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard src/*.sv) $(wildcard bench/*.sv)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BINARY)
	./$(BINARY)

clean:
	rm -rf $(BUILD_DIR)

//--- bench/exec_input.txt
# op rd src1 src2 imm f3 f7_5 pc dnpc reg_wen fencei valid ready btb_raddr mask | expected:
# val ren wen jump_wrong jump_addr btb_hit btb_target  (mask 01 val 02 lsu 04 jw 08 jaddr 10 hit 20 tgt)
100 1 5 3 0 0 0 1000 1004 1 0 1 1 0 1f 8 0 0 0 1004 0 0
100 2 3 5 0 0 1 1004 1008 1 0 1 1 0 0f fffffffe 0 0 0 1008 0 0
080 3 f0f0 0 ff 7 0 1008 100c 1 0 1 1 0 0f f0 0 0 0 100c 0 0
100 4 ff00ff00 ff00ff0 0 4 0 100c 1010 1 0 1 1 0 0f f0f0f0f0 0 0 0 1010 0 0
080 5 12340000 0 5678 6 0 1010 1014 1 0 1 1 0 0f 12345678 0 0 0 1014 0 0
100 6 1 1f 0 1 0 1014 1018 1 0 1 1 0 0f 80000000 0 0 0 1018 0 0
080 7 80000000 0 4 5 0 1018 101c 1 0 1 1 0 0f 8000000 0 0 0 101c 0 0
080 8 80000000 0 404 5 1 101c 1020 1 0 1 1 0 0f f8000000 0 0 0 1020 0 0
100 9 fffffff0 2 0 5 1 1020 1024 1 0 1 1 0 0f fffffffc 0 0 0 1024 0 0
100 a ffffffff 1 0 2 0 1024 1028 1 0 1 1 0 0f 1 0 0 0 1028 0 0
100 b ffffffff 1 0 3 0 1028 102c 1 0 1 1 0 0f 0 0 0 0 102c 0 0
080 c 5 0 fffffffb 2 0 102c 1030 1 0 1 1 0 0f 0 0 0 0 1030 0 0
080 d 5 0 fffffffb 3 0 1030 1034 1 0 1 1 0 0f 1 0 0 0 1034 0 0
001 e ffffffff 0 12345000 0 0 1034 1038 1 0 1 1 0 0f 12345000 0 0 0 1038 0 0
002 f 0 0 2000 0 0 1038 103c 1 0 1 1 0 0f 3038 0 0 0 103c 0 0
020 1 2000 0 8 2 0 103c 1040 1 0 1 1 0 0e 0 1 0 0 1040 0 0
040 0 2000 55 c 2 0 1040 1044 0 0 1 1 0 0e 0 0 1 0 1044 0 0
010 0 7 7 20 0 0 1100 1104 0 0 1 1 0 0c 0 0 0 1 1120 0 0
010 0 7 7 20 1 0 1120 1124 0 0 1 1 0 0c 0 0 0 0 1124 0 0
010 0 fffffff0 3 fffffff0 4 0 1200 1204 0 0 1 1 0 0c 0 0 0 1 11f0 0 0
010 0 fffffff0 3 20 5 0 1204 1208 0 0 1 1 1200 1c 0 0 0 0 1208 0 0
010 0 1 ffffffff 40 6 0 1208 1248 0 0 1 1 1200 3c 0 0 0 0 1248 1 11f0
010 0 ffffffff 1 10 7 0 1248 124c 0 0 1 1 0 0c 0 0 0 1 1258 0 0
004 1 0 0 fffffe00 0 0 1258 125c 1 0 1 1 1248 1d 125c 0 0 1 1058 0 0
008 1 3000 0 10 0 0 1058 105c 1 0 1 1 0 0d 105c 0 0 1 3010 0 0
008 1 4000 0 4 0 0 3010 4004 1 0 1 1 1258 3d 3014 0 0 0 4004 1 1058
000 0 0 0 0 0 0 4004 4008 0 1 1 1 0 0c 0 0 0 1 4008 0 0
004 1 0 0 100 0 0 5000 5004 1 0 0 1 0 0c 0 0 0 0 4008 0 0
004 1 0 0 100 0 0 5000 5004 1 0 1 0 0 0c 0 0 0 0 4008 0 0
200 1 0 0 300 2 0 6000 6004 1 0 1 1 0 0d 1800 0 0 0 6004 0 0
200 0 8000 0 305 1 0 6004 6008 0 0 1 1 0 0d 0 0 0 0 6008 0 0
200 0 12345678 0 340 1 0 6008 600c 0 0 1 1 0 0d 0 0 0 0 600c 0 0
200 2 f000000 0 340 2 0 600c 6010 1 0 1 1 0 0d 12345678 0 0 0 6010 0 0
200 2 0 0 340 2 0 6010 6014 1 0 1 1 0 0d 1f345678 0 0 0 6014 0 0
200 2 abcd 0 340 1 0 6014 6018 1 0 1 1 0 0d 1f345678 0 0 0 6018 0 0
200 2 0 0 340 2 0 6018 601c 1 0 1 1 0 0d abcd 0 0 0 601c 0 0
200 0 0 0 0 0 0 601c 6020 0 0 1 1 0 0c 0 0 0 1 8000 0 0
200 3 0 0 341 2 0 8000 8004 1 0 1 1 0 0d 601c 0 0 0 8004 0 0
200 3 0 0 342 2 0 8004 8008 1 0 1 1 0 0d b 0 0 0 8008 0 0
200 0 0 0 302 0 0 8008 800c 0 0 1 1 0 0c 0 0 0 1 601c 0 0
200 3 0 0 7c0 2 0 601c 6020 1 0 1 1 0 0d 0 0 0 0 6020 0 0
200 3 0 0 341 2 0 6020 6024 1 0 1 1 0 0d 601c 0 0 0 6024 0 0

//--- bench/exec_tb.sv
`timescale 1ns/1ps

module exec_tb import exec_pkg::*; ();

	localparam string INPUT_FILE = "bench/exec_input.txt";
	localparam int    NUM_FIELDS = 22;
	localparam int    MAX_VEC    = 128;

	// mask bits: 0 val, 1 lsu strobes, 2 jump_wrong, 3 jump_addr, 4 btb_hit, 5 btb_target
	typedef struct packed {
		exu_issue_t issue;
		logic       valid;
		logic       ready;
		btb_pc_t    braddr;
		logic [7:0] mask;
		word_t      val;
		logic       ren;
		logic       wen;
		logic       jw;
		word_t      jaddr;
		logic       hit;
		word_t      target;
	} vector_t;

	logic       clock;
	logic       arst_n;
	exu_issue_t issue;
	logic       exu_valid;
	logic       exu_ready;
	btb_pc_t    btb_raddr;
	word_t      val;
	logic       lsu_ren;
	logic       lsu_wen;
	reg_idx_t   rd_next;
	logic       reg_wen_next;
	word_t      jump_addr;
	btb_pc_t    pc_next;
	logic       jump_wrong;
	logic       btb_hit;
	word_t      btb_target;

	vector_t  vectors [MAX_VEC];
	word_t    fields  [NUM_FIELDS]; // tokens of the line being parsed
	int       field_cnt;
	int       num_vec;
	int       vec_idx;
	int       cur_vec; // vector that the running check belongs to
	logic     loaded;
	reg_idx_t exp_rd; // last accepted instruction
	logic     exp_reg_wen;
	btb_pc_t  exp_pc_next;

	exec_top exec_top_i (
		.clock        (clock),
		.arst_n       (arst_n),
		.issue        (issue),
		.exu_valid    (exu_valid),
		.exu_ready    (exu_ready),
		.btb_raddr    (btb_raddr),
		.val          (val),
		.lsu_ren      (lsu_ren),
		.lsu_wen      (lsu_wen),
		.rd_next      (rd_next),
		.reg_wen_next (reg_wen_next),
		.jump_addr    (jump_addr),
		.pc_next      (pc_next),
		.jump_wrong   (jump_wrong),
		.btb_hit      (btb_hit),
		.btb_target   (btb_target)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic abort(input string why);
		$display(">>> FAIL");
		$fatal(1, "%s", why);
	endtask

	task automatic check(input string name, input word_t got, input word_t expected);
		if (got !== expected) begin
			$display("FAILED %s: got 0x%08h, expected 0x%08h (vector %0d)",
			         name, got, expected, cur_vec);
			abort("stopped at first mismatch");
		end
	endtask

	// splits one line into hex tokens
	task automatic parse_line(input string line);
		int         i;
		int         start;
		logic [7:0] c;
		string      tok;
		field_cnt = 0;
		start     = -1;
		for (i = 0; i <= line.len(); i++) begin
			c = (i < line.len()) ? line.getc(i) : 8'h20;
			if (c == 8'h20 || c == 8'h09 || c == 8'h0a || c == 8'h0d) begin
				if (start >= 0) begin
					tok = line.substr(start, i - 1);
					if (field_cnt < NUM_FIELDS)
						fields[field_cnt] = word_t'(tok.atohex());
					field_cnt++;
					start = -1;
				end
			end else if (start < 0) begin
				start = i;
			end
		end
	endtask

	function automatic vector_t make_vector();
		vector_t v;
		v.issue.opcode_type = fields[0][9:0];
		v.issue.rd          = fields[1][3:0];
		v.issue.src1        = fields[2];
		v.issue.src2        = fields[3];
		v.issue.imm         = fields[4];
		v.issue.funct3      = fields[5][2:0];
		v.issue.funct7_5    = fields[6][0];
		v.issue.pc          = fields[7];
		v.issue.dnpc        = fields[8];
		v.issue.reg_wen     = fields[9][0];
		v.issue.inst_fencei = fields[10][0];
		v.valid             = fields[11][0];
		v.ready             = fields[12][0];
		v.braddr            = fields[13][24:0];
		v.mask              = fields[14][7:0];
		v.val               = fields[15];
		v.ren               = fields[16][0];
		v.wen               = fields[17][0];
		v.jw                = fields[18][0];
		v.jaddr             = fields[19];
		v.hit               = fields[20][0];
		v.target            = fields[21];
		return v;
	endfunction

	task automatic load_vectors();
		int    fd;
		string line;
		fd = $fopen(INPUT_FILE, "r");
		if (fd == 0) begin
			abort({"could not open the stimulus file ", INPUT_FILE});
		end else begin
			while ($fgets(line, fd) > 0) begin
				if (line.len() > 1 && line.getc(0) != "#") begin // skip comments
					parse_line(line);
					if (field_cnt != NUM_FIELDS)
						abort($sformatf("vector %0d has %0d fields instead of %0d",
						                num_vec, field_cnt, NUM_FIELDS));
					else if (num_vec == MAX_VEC)
						abort("too many vectors in the stimulus file");
					else begin
						vectors[num_vec] = make_vector();
						num_vec++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// same-cycle outputs of the vector just driven
	task automatic check_comb(input int idx);
		vector_t v;
		v       = vectors[idx];
		cur_vec = idx;
		if (v.mask[0])
			check("val", val, v.val);
		if (v.mask[1]) begin
			check("lsu_ren", 32'(lsu_ren), 32'(v.ren));
			check("lsu_wen", 32'(lsu_wen), 32'(v.wen));
		end
		if (v.mask[4])
			check("btb_hit", 32'(btb_hit), 32'(v.hit));
		if (v.mask[5])
			check("btb_target", btb_target, v.target);
	endtask

	// registered outputs, one cycle after the vector
	task automatic check_redirect(input int idx);
		vector_t v;
		v       = vectors[idx];
		cur_vec = idx;
		if (v.valid && v.ready) begin // otherwise the registers hold
			exp_rd      = v.issue.rd;
			exp_reg_wen = v.issue.reg_wen;
			exp_pc_next = v.issue.pc[24:0];
		end
		if (v.mask[2])
			check("jump_wrong", 32'(jump_wrong), 32'(v.jw));
		if (v.mask[3])
			check("jump_addr", jump_addr, v.jaddr);
		check("rd_next", 32'(rd_next), 32'(exp_rd));
		check("reg_wen_next", 32'(reg_wen_next), 32'(exp_reg_wen));
		check("pc_next", 32'(pc_next), 32'(exp_pc_next));
	endtask

	initial begin
		wait (loaded);
		repeat (num_vec * 20 + 100) @(posedge clock);
		abort("timeout, the vectors did not finish in time");
	end

	initial begin
		issue       = '0;
		exu_valid   = 1'b0;
		exu_ready   = 1'b0;
		btb_raddr   = '0;
		arst_n      = 1'b0;
		num_vec     = 0;
		cur_vec     = 0;
		loaded      = 1'b0;
		exp_rd      = '0;
		exp_reg_wen = 1'b0; // reset value
		exp_pc_next = '0;
		load_vectors();
		if (num_vec == 0)
			abort("the stimulus file holds no vectors");
		loaded = 1'b1;
		repeat (2) @(posedge clock);
		arst_n <= 1'b1;
		for (vec_idx = 0; vec_idx < num_vec; vec_idx++) begin
			@(posedge clock);
			issue     <= vectors[vec_idx].issue;
			exu_valid <= vectors[vec_idx].valid;
			exu_ready <= vectors[vec_idx].ready;
			btb_raddr <= vectors[vec_idx].braddr;
			@(negedge clock);
			check_comb(vec_idx);
			if (vec_idx > 0)
				check_redirect(vec_idx - 1);
		end
		@(posedge clock);
		exu_valid <= 1'b0; // idle so the last redirect can be seen
		@(negedge clock);
		check_redirect(num_vec - 1);
		$display(">>> PASS");
		$finish;
	end

endmodule

//--- src/exec_top.sv
`timescale 1ns/1ps

module exec_top import exec_pkg::*; (
	input  logic       clock,
	input  logic       arst_n,
	input  exu_issue_t issue,
	input  logic       exu_valid,
	input  logic       exu_ready,
	input  btb_pc_t    btb_raddr,
	output word_t      val,
	output logic       lsu_ren,
	output logic       lsu_wen,
	output reg_idx_t   rd_next,
	output logic       reg_wen_next,
	output word_t      jump_addr,
	output btb_pc_t    pc_next,
	output logic       jump_wrong,
	output logic       btb_hit,
	output word_t      btb_target
);

	word_t       loperand;
	word_t       roperand;
	word_t       alu_val;
	word_t       alu_sum;
	logic        branch_taken;
	word_t       csr_val;
	logic        csr_jump_en;
	word_t       csr_jump;
	logic        csr_enable;
	word_t       csr_wdata;
	logic        accept;
	logic        btb_wvalid;
	btb_update_t btb_wr;

	exu exu_i (
		.clock        (clock),
		.arst_n       (arst_n),
		.issue        (issue),
		.exu_valid    (exu_valid),
		.exu_ready    (exu_ready),
		.alu_val      (alu_val),
		.alu_sum      (alu_sum),
		.branch_taken (branch_taken),
		.csr_val      (csr_val),
		.csr_jump_en  (csr_jump_en),
		.csr_jump     (csr_jump),
		.loperand     (loperand),
		.roperand     (roperand),
		.val          (val),
		.lsu_ren      (lsu_ren),
		.lsu_wen      (lsu_wen),
		.csr_enable   (csr_enable),
		.csr_wdata    (csr_wdata),
		.accept       (accept),
		.rd_next      (rd_next),
		.reg_wen_next (reg_wen_next),
		.jump_addr    (jump_addr),
		.pc_next      (pc_next),
		.jump_wrong   (jump_wrong),
		.btb_wvalid   (btb_wvalid),
		.btb_wr       (btb_wr)
	);

	exec_alu exec_alu_i (
		.opcode_type (issue.opcode_type),
		.funct3      (issue.funct3),
		.funct7_5    (issue.funct7_5),
		.loperand    (loperand),
		.roperand    (roperand),
		.alu_val     (alu_val),
		.sum         (alu_sum)
	);

	branch_unit branch_unit_i (
		.src1         (issue.src1),
		.src2         (issue.src2),
		.funct3       (issue.funct3),
		.branch_taken (branch_taken)
	);

	csr_file csr_file_i (
		.clock       (clock),
		.arst_n      (arst_n),
		.accept      (accept),
		.opcode_type (issue.opcode_type),
		.funct3      (issue.funct3),
		.csr_addr    (issue.imm[11:0]), // csr number or ecall/mret code
		.pc          (issue.pc),
		.csr_enable  (csr_enable),
		.csr_wdata   (csr_wdata),
		.csr_val     (csr_val),
		.csr_jump_en (csr_jump_en),
		.csr_jump    (csr_jump)
	);

	btb btb_i (
		.clock      (clock),
		.arst_n     (arst_n),
		.btb_wvalid (btb_wvalid),
		.btb_wr     (btb_wr),
		.btb_raddr  (btb_raddr),
		.btb_hit    (btb_hit),
		.btb_target (btb_target)
	);

endmodule

//--- src/btb.sv
`timescale 1ns/1ps

module btb import exec_pkg::*; (
	input  logic        clock,
	input  logic        arst_n,
	input  logic        btb_wvalid,
	input  btb_update_t btb_wr,
	input  btb_pc_t     btb_raddr,
	output logic        btb_hit,
	output word_t       btb_target
);

	logic [BTB_ENTRIES-1:0] valid_q;
	logic [BTB_TAG_W-1:0]   tag_q    [BTB_ENTRIES];
	word_t                  target_q [BTB_ENTRIES];

	logic [BTB_IDX_W-1:0] widx;
	logic [BTB_IDX_W-1:0] ridx;
	logic [BTB_TAG_W-1:0] wtag;
	logic [BTB_TAG_W-1:0] rtag;

	// pc bits 1:0 are always zero and not stored
	assign widx = btb_wr.pc[2 +: BTB_IDX_W];
	assign ridx = btb_raddr[2 +: BTB_IDX_W];
	assign wtag = btb_wr.pc[$bits(btb_pc_t)-1 -: BTB_TAG_W];
	assign rtag = btb_raddr[$bits(btb_pc_t)-1 -: BTB_TAG_W];

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= '0;
		end else if (btb_wvalid) begin
			valid_q[widx] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (btb_wvalid) begin
			tag_q[widx]    <= wtag;
			target_q[widx] <= btb_wr.target;
		end
	end

	assign btb_hit    = valid_q[ridx] & (tag_q[ridx] == rtag);
	assign btb_target = target_q[ridx];

endmodule

//--- src/csr_file.sv
`timescale 1ns/1ps

module csr_file import exec_pkg::*; (
	input  logic         clock,
	input  logic         arst_n,
	input  logic         accept,
	input  opcode_type_t opcode_type,
	input  logic [2:0]   funct3,
	input  logic [11:0]  csr_addr,
	input  word_t        pc,
	input  logic         csr_enable,
	input  word_t        csr_wdata,
	output word_t        csr_val,
	output logic         csr_jump_en,
	output word_t        csr_jump
);

	word_t mstatus;
	word_t mtvec;
	word_t mepc;
	word_t mcause;
	word_t mscratch;
	logic  is_system; // funct3 == 0 in the system opcode
	logic  is_ecall;
	logic  is_mret;

	assign is_system = opcode_type[INST_CSR] & (funct3 == 3'b000);
	assign is_ecall  = is_system & (csr_addr == CSR_FUNCT_ECALL);
	assign is_mret   = is_system & (csr_addr == CSR_FUNCT_MRET);

	assign csr_jump_en = is_ecall | is_mret;
	assign csr_jump    = is_ecall ? mtvec : mepc;

	always_comb begin
		case (csr_addr)
			CSR_MSTATUS:  csr_val = mstatus;
			CSR_MTVEC:    csr_val = mtvec;
			CSR_MEPC:     csr_val = mepc;
			CSR_MCAUSE:   csr_val = mcause;
			CSR_MSCRATCH: csr_val = mscratch;
			default:      csr_val = 32'b0;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			mstatus  <= 32'h0000_1800; // mpp = machine
			mtvec    <= 32'b0;
			mepc     <= 32'b0;
			mcause   <= 32'b0;
			mscratch <= 32'b0;
		end else if (accept) begin
			if (csr_enable) begin
				case (csr_addr)
					CSR_MSTATUS:  mstatus  <= csr_wdata;
					CSR_MTVEC:    mtvec    <= csr_wdata;
					CSR_MEPC:     mepc     <= csr_wdata;
					CSR_MCAUSE:   mcause   <= csr_wdata;
					CSR_MSCRATCH: mscratch <= csr_wdata;
					default:      ;
				endcase
			end
			if (is_ecall) begin
				mepc   <= pc;
				mcause <= MCAUSE_ECALL_M;
			end
		end
	end

	// csr_enable comes from exu, trap decode from here
	a_csr_excl: assert property (
		@(posedge clock) disable iff (!arst_n) !(csr_enable && csr_jump_en)
	) else $error("csr write and trap in the same instruction");

endmodule

//--- src/exu.sv
`timescale 1ns/1ps

module exu import exec_pkg::*; (
	input  logic        clock,
	input  logic        arst_n,
	input  exu_issue_t  issue,
	input  logic        exu_valid,
	input  logic        exu_ready,
	input  word_t       alu_val,
	input  word_t       alu_sum,
	input  logic        branch_taken,
	input  word_t       csr_val,
	input  logic        csr_jump_en,
	input  word_t       csr_jump,
	output word_t       loperand,
	output word_t       roperand,
	output word_t       val,
	output logic        lsu_ren,
	output logic        lsu_wen,
	output logic        csr_enable,
	output word_t       csr_wdata,
	output logic        accept,
	output reg_idx_t    rd_next,
	output logic        reg_wen_next,
	output word_t       jump_addr,
	output btb_pc_t     pc_next,
	output logic        jump_wrong,
	output logic        btb_wvalid,
	output btb_update_t btb_wr
);

	word_t snpc;
	word_t npc; // resolved next pc
	logic  link;
	logic  jump_en;
	logic  need_btb;

	assign accept  = exu_valid & exu_ready;
	assign snpc    = issue.pc + 32'd4;
	assign link    = issue.opcode_type[INST_JAL] | issue.opcode_type[INST_JALR];
	assign jump_en = link | (issue.opcode_type[INST_BEQ] & branch_taken);

	assign loperand = (issue.opcode_type[INST_AUIPC] | issue.opcode_type[INST_JAL] |
	                   issue.opcode_type[INST_BEQ]) ? issue.pc :
	                  issue.opcode_type[INST_LUI] ? 32'b0 :
	                  issue.src1;
	assign roperand = issue.opcode_type[INST_ADD] ? issue.src2 : issue.imm;

	assign csr_enable = issue.opcode_type[INST_CSR] & (issue.funct3 != 3'b000);
	assign csr_wdata  = (issue.funct3 == 3'b010) ? (issue.src1 | csr_val) : // csrrs
	                    (issue.funct3 == 3'b001) ? issue.src1 :             // csrrw
	                    32'b0;

	assign val = link ? snpc :
	             csr_enable ? csr_val :
	             alu_val;

	assign lsu_ren = issue.opcode_type[INST_LW];
	assign lsu_wen = issue.opcode_type[INST_SW];

	assign npc = csr_jump_en ? csr_jump :
	             jump_en ? alu_sum :
	             snpc;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			reg_wen_next <= 1'b0;
			jump_wrong   <= 1'b0;
			need_btb     <= 1'b0;
		end else if (accept) begin
			reg_wen_next <= issue.reg_wen;
			jump_wrong   <= (npc != issue.dnpc) | issue.inst_fencei;
			need_btb     <= (issue.opcode_type[INST_BEQ] & issue.imm[31]) |
			                issue.opcode_type[INST_JAL]; // backward branch or jal
		end else begin
			jump_wrong   <= 1'b0; // redirect is a single pulse
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			rd_next   <= issue.rd;
			jump_addr <= npc;
			pc_next   <= issue.pc[$bits(btb_pc_t)-1:0];
		end
	end

	assign btb_wvalid    = jump_wrong & need_btb;
	assign btb_wr.pc     = pc_next;
	assign btb_wr.target = jump_addr;

	// operand and next-pc muxes rely on a single class bit
	a_onehot_class: assert property (
		@(posedge clock) disable iff (!arst_n) accept |-> $onehot0(issue.opcode_type)
	) else $error("instruction class is not one-hot");

endmodule

//--- src/branch_unit.sv
`timescale 1ns/1ps

module branch_unit import exec_pkg::*; (
	input  word_t      src1,
	input  word_t      src2,
	input  logic [2:0] funct3,
	output logic       branch_taken
);

	logic [32:0] diff;
	logic        equal;
	logic        less;
	logic        uless;

	assign diff  = {1'b0, src1} - {1'b0, src2};
	assign equal = (diff[31:0] == 32'b0);
	assign uless = diff[32]; // borrow out
	assign less  = (src1[31] & ~src2[31]) |
	               (~(src1[31] ^ src2[31]) & diff[31]);

	always_comb begin
		case (funct3)
			3'b000:  branch_taken = equal;  // beq
			3'b001:  branch_taken = ~equal; // bne
			3'b100:  branch_taken = less;   // blt
			3'b101:  branch_taken = ~less;  // bge
			3'b110:  branch_taken = uless;  // bltu
			3'b111:  branch_taken = ~uless; // bgeu
			default: branch_taken = 1'b0;   // 2 and 3 are not branches
		endcase
	end

endmodule

//--- src/exec_alu.sv
`timescale 1ns/1ps

module exec_alu import exec_pkg::*; (
	input  opcode_type_t opcode_type,
	input  logic [2:0]   funct3,
	input  logic         funct7_5,
	input  word_t        loperand,
	input  word_t        roperand,
	output word_t        alu_val,
	output word_t        sum
);

	alu_op_t     alu_op;
	logic [32:0] diff; // bit 32 is the borrow
	logic        less;
	logic        uless;
	logic [4:0]  shamt;

	always_comb begin
		alu_op = OP_ADD; // address and link arithmetic
		if (opcode_type[INST_ADDI] | opcode_type[INST_ADD]) begin
			case (funct3)
				3'b000:  alu_op = (opcode_type[INST_ADD] & funct7_5) ? OP_SUB : OP_ADD;
				3'b001:  alu_op = OP_SLL;
				3'b010:  alu_op = OP_LESS;
				3'b011:  alu_op = OP_ULESS;
				3'b100:  alu_op = OP_XOR;
				3'b101:  alu_op = funct7_5 ? OP_SRA : OP_SRL;
				3'b110:  alu_op = OP_OR;
				default: alu_op = OP_AND;
			endcase
		end
	end

	assign sum   = loperand + roperand;
	assign diff  = {1'b0, loperand} - {1'b0, roperand};
	assign uless = diff[32];
	assign less  = (loperand[31] & ~roperand[31]) |
	               (~(loperand[31] ^ roperand[31]) & diff[31]);
	assign shamt = roperand[4:0];

	always_comb begin
		case (alu_op)
			OP_ADD:   alu_val = sum;
			OP_SUB:   alu_val = diff[31:0];
			OP_AND:   alu_val = loperand & roperand;
			OP_XOR:   alu_val = loperand ^ roperand;
			OP_OR:    alu_val = loperand | roperand;
			OP_SRL:   alu_val = loperand >> shamt;
			OP_SRA:   alu_val = word_t'($signed(loperand) >>> shamt);
			OP_SLL:   alu_val = loperand << shamt;
			OP_LESS:  alu_val = {31'b0, less};
			OP_ULESS: alu_val = {31'b0, uless};
			default:  alu_val = '0;
		endcase
	end

endmodule

//--- src/exec_pkg.sv
package exec_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0]  reg_idx_t; // rv32e, 16 registers
	typedef logic [24:0] btb_pc_t;
	typedef logic [9:0]  opcode_type_t;
	typedef logic [3:0]  alu_op_t;

	// one-hot bit positions in opcode_type_t
	localparam int unsigned INST_LUI   = 0;
	localparam int unsigned INST_AUIPC = 1;
	localparam int unsigned INST_JAL   = 2;
	localparam int unsigned INST_JALR  = 3;
	localparam int unsigned INST_BEQ   = 4; // all conditional branches
	localparam int unsigned INST_LW    = 5;
	localparam int unsigned INST_SW    = 6;
	localparam int unsigned INST_ADDI  = 7; // all reg-imm alu ops
	localparam int unsigned INST_ADD   = 8; // all reg-reg alu ops
	localparam int unsigned INST_CSR   = 9; // csr access, ecall, mret

	localparam alu_op_t OP_ADD   = 4'd0;
	localparam alu_op_t OP_SUB   = 4'd1;
	localparam alu_op_t OP_AND   = 4'd2;
	localparam alu_op_t OP_XOR   = 4'd3;
	localparam alu_op_t OP_OR    = 4'd4;
	localparam alu_op_t OP_SRL   = 4'd5;
	localparam alu_op_t OP_SRA   = 4'd6;
	localparam alu_op_t OP_SLL   = 4'd7;
	localparam alu_op_t OP_LESS  = 4'd8;
	localparam alu_op_t OP_ULESS = 4'd9;

	localparam logic [11:0] CSR_MSTATUS  = 12'h300;
	localparam logic [11:0] CSR_MTVEC    = 12'h305;
	localparam logic [11:0] CSR_MSCRATCH = 12'h340;
	localparam logic [11:0] CSR_MEPC     = 12'h341;
	localparam logic [11:0] CSR_MCAUSE   = 12'h342;

	localparam logic [11:0] CSR_FUNCT_ECALL = 12'h000;
	localparam logic [11:0] CSR_FUNCT_MRET  = 12'h302;
	localparam word_t       MCAUSE_ECALL_M  = 32'd11;

	localparam int unsigned BTB_ENTRIES = 16;
	localparam int unsigned BTB_IDX_W   = $clog2(BTB_ENTRIES);
	localparam int unsigned BTB_TAG_W   = $bits(btb_pc_t) - 2 - BTB_IDX_W;

	typedef struct packed {
		opcode_type_t opcode_type;
		reg_idx_t     rd;
		word_t        src1;
		word_t        src2;
		word_t        imm;
		logic [2:0]   funct3;
		logic         funct7_5;
		word_t        pc;
		word_t        dnpc; // predicted next pc from fetch
		logic         reg_wen;
		logic         inst_fencei;
	} exu_issue_t;

	typedef struct packed {
		btb_pc_t pc;
		word_t   target;
	} btb_update_t;

endpackage
